/* gda_adder_unit.f */
+incdir+hw
hw/gda_pkg.sv
hw/gda_carry_predict.sv
hw/gda_adder_core.sv
hw/gda_result_stage.sv
hw/gda_cfg_regs.sv
hw/gda_adder_unit.sv
tests/gda_adder_unit_tb.sv

/* hw/gda_adder_core.sv */
`default_nettype none

`include "gda_consts.svh"

module gda_adder_core (
    input  wire gda_pkg::operand_t   in1,
    input  wire gda_pkg::operand_t   in2,
    input  wire gda_pkg::depth_cfg_t depth_cfg,
    output gda_pkg::sum_t            approx_sum
);

    import gda_pkg::*;

    logic [`GDA_NUM_BLK-2:0] blk_cin;
    logic [`GDA_NUM_BLK-1:0] cin_all;

    gda_carry_predict u_carry_predict (
        .in1       (in1),
        .in2       (in2),
        .depth_cfg (depth_cfg),
        .blk_cin   (blk_cin)
    );

    // block 0 has no lower neighbour and always starts from zero
    assign cin_all = {blk_cin, 1'b0};

    genvar i;
    generate
        for (i = 0; i < `GDA_NUM_BLK; i++) begin : g_blk_add
            logic [`GDA_BLK_W:0] blk_sum;

            assign blk_sum = {1'b0, in1[i*`GDA_BLK_W +: `GDA_BLK_W]}
                           + {1'b0, in2[i*`GDA_BLK_W +: `GDA_BLK_W]}
                           + {{`GDA_BLK_W{1'b0}}, cin_all[i]};
            assign approx_sum[i*`GDA_BLK_W +: `GDA_BLK_W] = blk_sum[`GDA_BLK_W-1:0];

            // only the top block keeps its carry out
            if (i == `GDA_NUM_BLK - 1) begin : g_top
                assign approx_sum[`GDA_OP_W] = blk_sum[`GDA_BLK_W];
            end
        end
    endgenerate

endmodule

`default_nettype wire

/* hw/gda_adder_unit.sv */
`default_nettype none

module gda_adder_unit (
    input  wire                     clk,
    input  wire                     arst_n,

    // operand path
    input  wire                     in_valid,
    input  wire gda_pkg::operand_t  in1,
    input  wire gda_pkg::operand_t  in2,
    output logic                    out_valid,
    output gda_pkg::sum_t           res,
    output logic                    err,

    // configuration path
    input  wire                     cfg_we,
    input  wire gda_pkg::cfg_addr_t cfg_addr,
    input  wire gda_pkg::cfg_data_t cfg_wdata,
    output gda_pkg::cfg_data_t      cfg_rdata
);

    import gda_pkg::*;

    depth_cfg_t depth_cfg;
    sum_t       approx_sum;

    gda_cfg_regs u_cfg_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .res_valid (out_valid),
        .res_err   (err),
        .depth_cfg (depth_cfg)
    );

    gda_adder_core u_adder_core (
        .in1        (in1),
        .in2        (in2),
        .depth_cfg  (depth_cfg),
        .approx_sum (approx_sum)
    );

    // the exact sum is formed from the raw operands beside the core
    gda_result_stage u_result_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in1        (in1),
        .in2        (in2),
        .approx_sum (approx_sum),
        .out_valid  (out_valid),
        .res        (res),
        .err        (err)
    );

endmodule

`default_nettype wire

/* hw/gda_carry_predict.sv */
`default_nettype none

`include "gda_consts.svh"

module gda_carry_predict (
    input  wire gda_pkg::operand_t          in1,
    input  wire gda_pkg::operand_t          in2,
    input  wire gda_pkg::depth_cfg_t        depth_cfg,
    output logic [`GDA_NUM_BLK-2:0]         blk_cin
);

    import gda_pkg::*;

    // ########################################
    // block generate and propagate
    // ########################################

    // the top block never feeds a prediction, so only the lower ones are formed
    logic [`GDA_NUM_BLK-2:0] blk_g;
    logic [`GDA_NUM_BLK-2:0] blk_p;

    genvar i;
    generate
        for (i = 0; i < `GDA_NUM_BLK - 1; i++) begin : g_blk_gp
            logic [`GDA_BLK_W:0] part_sum;

            // carry out with a carry-in of zero is the block generate
            assign part_sum = {1'b0, in1[i*`GDA_BLK_W +: `GDA_BLK_W]}
                            + {1'b0, in2[i*`GDA_BLK_W +: `GDA_BLK_W]};
            assign blk_g[i] = part_sum[`GDA_BLK_W];
            assign blk_p[i] = &(in1[i*`GDA_BLK_W +: `GDA_BLK_W]
                              ^ in2[i*`GDA_BLK_W +: `GDA_BLK_W]);
        end
    endgenerate

    // ########################################
    // depth-limited lookahead
    // ########################################

    // walk upward from the lowest block inside the window and assume a zero
    // carry entering it. blocks outside the window are skipped. a depth of 0
    // leaves the window empty and gives no carry at all
    always_comb begin
        depth_t blk_depth;
        logic   chain;

        blk_cin = '0;
        for (int k = 1; k < `GDA_NUM_BLK; k++) begin
            blk_depth = depth_cfg[(k-1)*2 +: 2];
            chain     = 1'b0;
            for (int j = 0; j < k; j++) begin
                if (j >= k - int'(blk_depth)) begin
                    chain = blk_g[j] | (blk_p[j] & chain);
                end
            end
            blk_cin[k-1] = chain;
        end
    end

endmodule

`default_nettype wire

/* hw/gda_cfg_regs.sv */
`default_nettype none

`include "gda_consts.svh"

module gda_cfg_regs (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      cfg_we,
    input  wire gda_pkg::cfg_addr_t  cfg_addr,
    input  wire gda_pkg::cfg_data_t  cfg_wdata,
    output gda_pkg::cfg_data_t       cfg_rdata,
    input  wire                      res_valid,
    input  wire                      res_err,
    output gda_pkg::depth_cfg_t      depth_cfg
);

    import gda_pkg::*;

    cnt_t ops_cnt;
    cnt_t err_cnt;
    logic depth_we;
    logic cnt_clr;

    // ########################################
    // write decode
    // ########################################

    assign depth_we = cfg_we && (cfg_addr == `GDA_ADDR_DEPTH);

    // either counter address clears both
    assign cnt_clr = cfg_we
                  && ((cfg_addr == `GDA_ADDR_ERRS) || (cfg_addr == `GDA_ADDR_OPS));

    // ########################################
    // depth register
    // ########################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            depth_cfg <= `GDA_DEPTH_RST;
        end else if (depth_we) begin
            depth_cfg <= cfg_wdata[$bits(depth_cfg_t)-1:0];
        end
    end

    // ########################################
    // result and error counters
    // ########################################

    // both counters stop at all ones, a clear takes priority over counting
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ops_cnt <= '0;
            err_cnt <= '0;
        end else if (cnt_clr) begin
            ops_cnt <= '0;
            err_cnt <= '0;
        end else if (res_valid) begin
            if (ops_cnt != '1) begin
                ops_cnt <= ops_cnt + 1'b1;
            end
            if (res_err && (err_cnt != '1)) begin
                err_cnt <= err_cnt + 1'b1;
            end
        end
    end

    // ########################################
    // read mux
    // ########################################

    always_comb begin
        case (cfg_addr)
            `GDA_ADDR_DEPTH: cfg_rdata = cfg_data_t'(depth_cfg);
            `GDA_ADDR_ERRS:  cfg_rdata = err_cnt;
            `GDA_ADDR_OPS:   cfg_rdata = ops_cnt;
            default:         cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/gda_consts.svh */
`ifndef GDA_CONSTS_SVH
`define GDA_CONSTS_SVH

// ########################################
// datapath geometry
// ########################################

`define GDA_OP_W      16
`define GDA_BLK_W     4
`define GDA_NUM_BLK   4

// ########################################
// configuration map
// ########################################

`define GDA_ADDR_DEPTH 2'd0
`define GDA_ADDR_ERRS  2'd1
`define GDA_ADDR_OPS   2'd2

// depth 2 in the fields of blocks 1, 2 and 3
`define GDA_DEPTH_RST  6'h2a

`endif

/* hw/gda_pkg.sv */
`default_nettype none

`include "gda_consts.svh"

package gda_pkg;

    typedef logic [`GDA_OP_W-1:0] operand_t;

    // one extra bit for the carry out of the top block
    typedef logic [`GDA_OP_W:0] sum_t;

    // 0 means no carry-in, otherwise the number of lower blocks looked at
    typedef logic [1:0] depth_t;

    // one depth field per upper block, block 1 in the low bits
    typedef logic [2*(`GDA_NUM_BLK-1)-1:0] depth_cfg_t;

    typedef logic [15:0] cnt_t;

    typedef logic [1:0] cfg_addr_t;

    typedef logic [15:0] cfg_data_t;

endpackage

`default_nettype wire

/* hw/gda_result_stage.sv */
`default_nettype none

module gda_result_stage (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    in_valid,
    input  wire gda_pkg::operand_t in1,
    input  wire gda_pkg::operand_t in2,
    input  wire gda_pkg::sum_t     approx_sum,
    output logic                   out_valid,
    output gda_pkg::sum_t          res,
    output logic                   err
);

    import gda_pkg::*;

    sum_t exact_sum;
    logic mismatch;

    // ########################################
    // exact reference
    // ########################################

    assign exact_sum = {1'b0, in1} + {1'b0, in2};
    assign mismatch  = (exact_sum != approx_sum);

    // ########################################
    // output registers
    // ########################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // result and flag hold their value between operands
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res <= '0;
            err <= 1'b0;
        end else if (in_valid) begin
            res <= approx_sum;
            err <= mismatch;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
# A failing check ends the simulation with $fatal, which gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f gda_adder_unit.f \
    --top-module gda_adder_unit_tb \
    -o gda_sim

./obj_dir/gda_sim

/* tests/gda_adder_unit_tb.sv */
`default_nettype none

`include "gda_consts.svh"

module gda_adder_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import gda_pkg::*;

    localparam int CLK_PERIOD = 8;

    logic      clk;
    logic      arst_n;
    logic      in_valid;
    operand_t  in1;
    operand_t  in2;
    logic      out_valid;
    sum_t      res;
    logic      err;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wdata;
    cfg_data_t cfg_rdata;

    // parsed test lines
    string       kind_q[$];
    string       name_q[$];
    logic [31:0] f1_q[$];
    logic [31:0] f2_q[$];
    logic [31:0] f3_q[$];
    logic [31:0] f4_q[$];
    bit          rnd_q[$];
    bit          calc_q[$];

    int          n_lines;
    int          n_rand;
    bit          parse_done;
    integer      seed;
    depth_cfg_t  cur_depth;
    logic [31:0] ops_seen;
    logic [31:0] errs_seen;

    // result expected on the next cycle
    bit          pend_valid;
    string       pend_name;
    sum_t        pend_res;
    logic        pend_err;

    gda_adder_unit DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in1       (in1),
        .in2       (in2),
        .out_valid (out_valid),
        .res       (res),
        .err       (err),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ########################################
    // helpers
    // ########################################

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %0h, actual %0h", test_name, expected, actual);
            abort_run("the DUT returned a wrong value");
        end
    endtask

    // fields marked r or - carry no number and read as zero
    function automatic logic [31:0] hex_field(input string s);
        logic [31:0] v;
        if ($sscanf(s, "%h", v) != 1) begin
            v = '0;
        end
        return v;
    endfunction

    // each block gets the carry out of its window of lower blocks, with a zero
    // carry entering the lowest block of the window
    function automatic sum_t predict_sum(input operand_t a, input operand_t b,
                                         input depth_cfg_t depth);
        sum_t       s;
        logic [4:0] blk;
        logic       c;
        logic       cin;
        int         d;
        int         lo;
        s = '0;
        for (int k = 0; k < 4; k++) begin
            cin = 1'b0;
            if (k > 0) begin
                d = int'(depth[2*(k-1) +: 2]);
                if (d != 0) begin
                    lo = (k - d < 0) ? 0 : k - d;
                    c  = 1'b0;
                    for (int j = lo; j < k; j++) begin
                        blk = {1'b0, a[4*j +: 4]} + {1'b0, b[4*j +: 4]} + {4'd0, c};
                        c   = blk[4];
                    end
                    cin = c;
                end
            end
            blk = {1'b0, a[4*k +: 4]} + {1'b0, b[4*k +: 4]} + {4'd0, cin};
            s[4*k +: 4] = blk[3:0];
            if (k == 3) begin
                s[16] = blk[4];
            end
        end
        return s;
    endfunction

    task automatic drive_inputs(input logic v, input operand_t a, input operand_t b,
                                input logic we, input cfg_addr_t addr, input cfg_data_t wdata);
        @(posedge clk);
        in_valid  <= v;
        in1       <= a;
        in2       <= b;
        cfg_we    <= we;
        cfg_addr  <= addr;
        cfg_wdata <= wdata;
    endtask

    // outputs are sampled on the falling edge, half a cycle after they settle
    task automatic check_pending();
        @(negedge clk);
        check_value({pend_name, " out_valid"}, {31'd0, pend_valid}, {31'd0, out_valid});
        if (pend_valid) begin
            check_value({pend_name, " res"}, {15'd0, pend_res}, {15'd0, res});
            check_value({pend_name, " err"}, {31'd0, pend_err}, {31'd0, err});
        end
    endtask

    // ########################################
    // watchdog
    // ########################################

    initial begin
        wait (parse_done);
        #(CLK_PERIOD * (n_lines + n_rand + 20));
        abort_run("Timeout: the test lines did not complete in the allowed time");
    end

    // ########################################
    // stimulus and checks
    // ########################################

    initial begin
        integer      fd;
        integer      rc;
        bit          done;
        string       kind;
        string       name;
        string       s1;
        string       s2;
        string       s3;
        string       s4;
        string       rest;
        logic [31:0] r1;
        logic [31:0] r2;
        operand_t    a;
        operand_t    b;
        sum_t        exp_res;
        logic        exp_err;
        logic [31:0] exp_val;
        cfg_addr_t   addr;

        arst_n     <= 1'b0;
        in_valid   <= 1'b0;
        in1        <= '0;
        in2        <= '0;
        cfg_we     <= 1'b0;
        cfg_addr   <= '0;
        cfg_wdata  <= '0;
        seed       = 32'hd41e;
        n_lines    = 0;
        n_rand     = 0;
        parse_done = 1'b0;
        pend_valid = 1'b0;
        pend_name  = "reset";
        cur_depth  = `GDA_DEPTH_RST;
        ops_seen   = '0;
        errs_seen  = '0;

        fd = $fopen("tests/gda_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the test file tests/gda_tests.txt");
        end
        done = 1'b0;
        while (!done) begin
            rc = $fscanf(fd, "%s", kind);
            if (rc != 1) begin
                done = 1'b1;
            end else if (kind.getc(0) == "#") begin
                rc = $fgets(rest, fd);
            end else if (kind == "A") begin
                rc = $fscanf(fd, "%s %s %s %s %s", name, s1, s2, s3, s4);
                if (rc != 5) begin
                    abort_run({"malformed operand line ", name});
                end
                kind_q.push_back(kind);
                name_q.push_back(name);
                f1_q.push_back(hex_field(s1));
                f2_q.push_back(hex_field(s2));
                f3_q.push_back(hex_field(s3));
                f4_q.push_back(hex_field(s4));
                rnd_q.push_back(s1 == "r");
                calc_q.push_back(s3 == "-");
                n_lines++;
                if (s1 == "r") begin
                    n_rand++;
                end
            end else if (kind == "W" || kind == "R") begin
                rc = $fscanf(fd, "%s %s %s", name, s1, s2);
                if (rc != 3) begin
                    abort_run({"malformed configuration line ", name});
                end
                kind_q.push_back(kind);
                name_q.push_back(name);
                f1_q.push_back(hex_field(s1));
                f2_q.push_back(hex_field(s2));
                f3_q.push_back('0);
                f4_q.push_back('0);
                rnd_q.push_back(1'b0);
                calc_q.push_back(s2 == "-");
                n_lines++;
            end else begin
                abort_run({"unknown line kind ", kind, " in the test file"});
            end
        end
        $fclose(fd);
        parse_done = 1'b1;

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < kind_q.size(); i++) begin
            addr = f1_q[i][1:0];
            if (kind_q[i] == "A") begin
                if (rnd_q[i]) begin
                    r1 = $random(seed);
                    r2 = $random(seed);
                    a  = r1[15:0];
                    b  = r2[15:0];
                end else begin
                    a = f1_q[i][15:0];
                    b = f2_q[i][15:0];
                end
                if (calc_q[i]) begin
                    exp_res = predict_sum(a, b, cur_depth);
                    exp_err = (exp_res != ({1'b0, a} + {1'b0, b}));
                end else begin
                    exp_res = f3_q[i][16:0];
                    exp_err = f4_q[i][0];
                end
                drive_inputs(1'b1, a, b, 1'b0, '0, '0);
                check_pending();
                pend_valid = 1'b1;
                pend_res   = exp_res;
                pend_err   = exp_err;
                ops_seen   = ops_seen + 1;
                if (exp_err) begin
                    errs_seen = errs_seen + 1;
                end
            end else if (kind_q[i] == "W") begin
                drive_inputs(1'b0, '0, '0, 1'b1, addr, f2_q[i][15:0]);
                check_pending();
                pend_valid = 1'b0;
                if (addr == `GDA_ADDR_DEPTH) begin
                    cur_depth = f2_q[i][5:0];
                end else if (addr == `GDA_ADDR_ERRS || addr == `GDA_ADDR_OPS) begin
                    ops_seen  = '0;
                    errs_seen = '0;
                end
            end else begin
                // a second cycle lets the last result reach the counters
                drive_inputs(1'b0, '0, '0, 1'b0, addr, '0);
                check_pending();
                pend_valid = 1'b0;
                drive_inputs(1'b0, '0, '0, 1'b0, addr, '0);
                check_pending();
                if (!calc_q[i]) begin
                    exp_val = f2_q[i];
                end else if (addr == `GDA_ADDR_OPS) begin
                    exp_val = ops_seen;
                end else if (addr == `GDA_ADDR_ERRS) begin
                    exp_val = errs_seen;
                end else begin
                    abort_run({"no computed value exists for the read in ", name_q[i]});
                end
                check_value(name_q[i], exp_val, {16'd0, cfg_rdata});
            end
            pend_name = name_q[i];
        end

        drive_inputs(1'b0, '0, '0, 1'b0, '0, '0);
        check_pending();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/gda_tests.txt */
# W name addr data | R name addr expected | A name in1 in2 res err, all in hex
# r draws a random operand and - marks a value that the testbench computes
R rst_depth 0 002a
R rst_errs 1 0000
R rst_ops 2 0000
R rst_unmapped 3 0000
A rst_short 0012 0034 00046 0
A rst_ripple3 0fff 0001 00000 1
A rst_ripple2 00ff 0001 00100 0
A rst_gen 0880 0880 01100 0
A rst_ovf ffff 0001 0f000 1
R cnt_ops_a 2 0005
R cnt_errs_a 1 0002
W d3_cfg 0 003f
R d3_rd 0 003f
A d3_ovf ffff 0001 10000 0
A d3_ripple 0fff 0001 01000 0
A d3_mix 1234 edcc 10000 0
A d3_plain 7fff 7fff 0fffe 0
A d3_big ffff ffff 1fffe 0
W d0_cfg 0 0000
A d0_a 0fff 0001 00ff0 1
A d0_b 1111 2222 03333 0
A d0_c 0808 0808 00000 1
A d0_d ffff ffff 1eeee 1
A d0_e 8000 8000 10000 0
R cnt_ops_b 2 000f
R cnt_errs_b 1 0005
W clr_by_errs 1 0000
R clr_ops 2 0000
R clr_errs 1 0000
W mix_cfg 0 002d
R mix_rd 0 002d
A mix_fixed 00f8 0008 00100 0
A mix_miss 0ff8 0008 00000 1
A mix_rnd_0 r r - -
A mix_rnd_1 r r - -
A mix_rnd_2 r r - -
A mix_rnd_3 r r - -
A mix_rnd_4 r r - -
A mix_rnd_5 r r - -
A mix_rnd_6 r r - -
A mix_rnd_7 r r - -
R mix_ops 2 -
R mix_errs 1 -
W clr_by_ops 2 0000
R clr_ops_b 2 0000
R clr_errs_b 1 0000
